//--- hw/serialBridge_cfg.svh
/*
 * Serial bridge configuration
 * Sizes of the byte FIFO, the clear-to-send level and the stream frame length
 */
`ifndef SERIAL_BRIDGE_CFG_SVH
`define SERIAL_BRIDGE_CFG_SVH

// Byte entries in the receive FIFO, must be a power of two
`define SB_FIFO_DEPTH 64

// CTS stays high while the fill count is at or below this level
// Leave room for the bytes the host may still have in flight
`define SB_CTS_THRESHOLD 16

// Stream beats per frame, the last one carries tlast
`define SB_WORDS_PER_FRAME 4

`endif

//--- hw/serialPkg.sv
/*
 * Serial side types
 * Byte, FIFO pointer and fill types, and the byte handed from receiver to FIFO
 */
`include "serialBridge_cfg.svh"

package serialPkg;

    localparam int FifoAddrWidth = $clog2(`SB_FIFO_DEPTH);

    typedef logic [7:0] spiByte_t;

    // Pointer into the FIFO storage
    typedef logic [FifoAddrWidth - 1 : 0] fifoAddr_t;

    // One bit wider than the pointer so a full FIFO can be counted
    typedef logic [FifoAddrWidth : 0] fifoFill_t;

    // Received byte with its one-cycle strobe
    typedef struct packed {
        spiByte_t data;
        logic     valid;
    } rxByte_t;

endpackage

//--- hw/streamPkg.sv
/*
 * Stream side types
 * Data word, beat payload and the word assembler states
 */
package streamPkg;

    typedef logic [31:0] streamWord_t;

    // Payload of one AXI-Stream beat
    typedef struct packed {
        streamWord_t data;
        logic        last;
    } streamBeat_t;

    // COLLECT pops bytes, OFFER is the first cycle with valid high,
    // WAIT_ACCEPT holds the beat under back-pressure
    typedef enum logic [1:0] {
        COLLECT     = 2'd0,
        OFFER       = 2'd1,
        WAIT_ACCEPT = 2'd2
    } assemblerState_t;

endpackage

//--- hw/spiReceiver.sv
/*
 * SPI mode-0 slave receiver
 * Brings SCK, NCS and MOSI into the aclk domain, assembles bytes MSB first
 * and echoes the previous byte on MISO
 */
`timescale 1ns/1ps

module spiReceiver
(
    input  logic               aclk,
    input  logic               resetn,
    input  logic               i_serialSck,
    input  logic               i_serialNcs,
    input  logic               i_serialMosi,
    output logic               o_serialMiso,
    output serialPkg::rxByte_t o_rx
);
    logic [1:0]          sckSync;
    logic [1:0]          ncsSync;
    logic [1:0]          mosiSync;
    logic                sckPrev;
    logic                sckRise;
    logic                sckFall;
    logic                byteDone;
    logic [2:0]          bitCnt;
    logic                rxValid;
    serialPkg::spiByte_t rxShift;
    serialPkg::spiByte_t echoByte;
    serialPkg::spiByte_t txShift;

    // Two-stage synchronizers, NCS idles high
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            sckSync  <= 2'b00;
            ncsSync  <= 2'b11;
            mosiSync <= 2'b00;
            sckPrev  <= 1'b0;
        end
        else
        begin
            sckSync  <= {sckSync[0], i_serialSck};
            ncsSync  <= {ncsSync[0], i_serialNcs};
            mosiSync <= {mosiSync[0], i_serialMosi};
            sckPrev  <= sckSync[1];
        end
    end

    assign sckRise  = sckSync[1] && !sckPrev;
    assign sckFall  = !sckSync[1] && sckPrev;
    assign byteDone = sckRise && !ncsSync[1] && (bitCnt == 3'd7);

    always_ff @(posedge aclk)
    begin
        if (sckRise && !ncsSync[1])
        begin
            rxShift <= {rxShift[6:0], mosiSync[1]};
        end
    end

    // echoByte doubles as the received byte towards the FIFO
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            bitCnt   <= 3'd0;
            rxValid  <= 1'b0;
            echoByte <= '0;
            txShift  <= '0;
        end
        else
        begin
            rxValid <= byteDone;
            if (byteDone)
            begin
                echoByte <= {rxShift[6:0], mosiSync[1]};
            end
            if (ncsSync[1])
            begin
                bitCnt  <= 3'd0;
                txShift <= echoByte;
            end
            else
            begin
                if (sckRise)
                begin
                    bitCnt <= bitCnt + 3'd1;
                end
                // Falling edge after the 8th bit starts the next echo byte
                if (sckFall)
                begin
                    if (bitCnt == 3'd0)
                        txShift <= echoByte;
                    else
                        txShift <= {txShift[6:0], 1'b0};
                end
            end
        end
    end

    assign o_serialMiso = txShift[7];
    assign o_rx         = '{data: echoByte, valid: rxValid};

    // The host only deselects between whole bytes
    wholeBytesOnly: assert property (@(posedge aclk) disable iff (!resetn)
        $rose(ncsSync[1]) |-> (bitCnt == 3'd0))
        else $error("CHECK FAILED at %0t: NCS rose in the middle of a byte", $time);

endmodule

//--- hw/byteFifo.sv
/*
 * First-word-fall-through byte FIFO
 * Circular buffer with fill count and a registered clear-to-send flag
 */
`timescale 1ns/1ps
`include "serialBridge_cfg.svh"

module byteFifo
(
    input  logic                aclk,
    input  logic                resetn,
    input  serialPkg::rxByte_t  i_rx,
    input  logic                i_pop,
    output serialPkg::spiByte_t o_head,
    output logic                o_empty,
    output logic                o_serialCts
);
    serialPkg::spiByte_t  mem [`SB_FIFO_DEPTH];
    serialPkg::fifoAddr_t wrPtr;
    serialPkg::fifoAddr_t rdPtr;
    serialPkg::fifoFill_t fill;
    logic                 full;
    logic                 doWrite;
    logic                 doPop;

    assign full    = (fill == serialPkg::fifoFill_t'(`SB_FIFO_DEPTH));
    assign o_empty = (fill == '0);
    assign doWrite = i_rx.valid && !full;
    assign doPop   = i_pop && !o_empty;

    always_ff @(posedge aclk)
    begin
        if (doWrite)
        begin
            mem[wrPtr] <= i_rx.data;
        end
    end

    // Head is read straight from storage
    assign o_head = mem[rdPtr];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            fill        <= '0;
            o_serialCts <= 1'b1;
        end
        else
        begin
            if (doWrite)
                wrPtr <= wrPtr + serialPkg::fifoAddr_t'(1);
            if (doPop)
                rdPtr <= rdPtr + serialPkg::fifoAddr_t'(1);
            case ({doWrite, doPop})
                2'b10:   fill <= fill + serialPkg::fifoFill_t'(1);
                2'b01:   fill <= fill - serialPkg::fifoFill_t'(1);
                default: fill <= fill;
            endcase
            o_serialCts <= (fill <= serialPkg::fifoFill_t'(`SB_CTS_THRESHOLD));
        end
    end

    // A byte on a full FIFO is lost, the host ignored CTS
    noWriteWhileFull: assert property (@(posedge aclk) disable iff (!resetn)
        i_rx.valid |-> !full)
        else $error("CHECK FAILED at %0t: byte dropped, FIFO full", $time);

endmodule

//--- hw/wordAssembler.sv
/*
 * Word assembler
 * Pops four bytes, first byte into the lowest lane, and offers the word
 * as one stream beat until it is accepted
 */
`timescale 1ns/1ps

module wordAssembler
(
    input  logic                   aclk,
    input  logic                   resetn,
    input  serialPkg::spiByte_t    i_head,
    input  logic                   i_empty,
    input  logic                   i_ready,
    input  logic                   i_lastBeat,
    output logic                   o_pop,
    output logic                   o_valid,
    output logic                   o_accept,
    output streamPkg::streamBeat_t o_beat
);
    streamPkg::assemblerState_t state;
    logic [1:0]                 lane;
    serialPkg::spiByte_t [3:0]  lanes;
    logic                       beatLast;
    logic                       take;

    // Pop stays high for the whole collect phase
    assign o_pop    = (state == streamPkg::COLLECT);
    assign take     = o_pop && !i_empty;
    assign o_accept = o_valid && i_ready;

    // Lanes are only written in COLLECT, so the beat holds while valid
    always_ff @(posedge aclk)
    begin
        if (take)
        begin
            lanes[lane] <= i_head;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state    <= streamPkg::COLLECT;
            lane     <= 2'd0;
            o_valid  <= 1'b0;
            beatLast <= 1'b0;
        end
        else
        begin
            case (state)
                streamPkg::COLLECT:
                begin
                    if (take)
                    begin
                        lane <= lane + 2'd1;
                        if (lane == 2'd3)
                        begin
                            beatLast <= i_lastBeat;
                            o_valid  <= 1'b1;
                            state    <= streamPkg::OFFER;
                        end
                    end
                end
                streamPkg::OFFER:
                begin
                    if (i_ready)
                    begin
                        o_valid <= 1'b0;
                        state   <= streamPkg::COLLECT;
                    end
                    else
                        state <= streamPkg::WAIT_ACCEPT;
                end
                streamPkg::WAIT_ACCEPT:
                begin
                    if (i_ready)
                    begin
                        o_valid <= 1'b0;
                        state   <= streamPkg::COLLECT;
                    end
                end
                default:
                    state <= streamPkg::COLLECT;
            endcase
        end
    end

    assign o_beat = '{data: streamPkg::streamWord_t'(lanes), last: beatLast};

    beatHeldUnderBackpressure: assert property (@(posedge aclk) disable iff (!resetn)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_beat)))
        else $error("CHECK FAILED at %0t: beat changed before accept", $time);

endmodule

//--- hw/frameCounter.sv
/*
 * Frame counter
 * Counts accepted beats and flags the beat that closes a frame
 */
`timescale 1ns/1ps
`include "serialBridge_cfg.svh"

module frameCounter
(
    input  logic aclk,
    input  logic resetn,
    input  logic i_accept,
    output logic o_lastBeat
);
    localparam int CntWidth = (`SB_WORDS_PER_FRAME > 1) ? $clog2(`SB_WORDS_PER_FRAME) : 1;
    localparam logic [CntWidth - 1 : 0] LastIdx = CntWidth'(`SB_WORDS_PER_FRAME - 1);

    logic [CntWidth - 1 : 0] beatCnt;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            beatCnt <= '0;
        end
        else if (i_accept)
        begin
            if (beatCnt == LastIdx)
                beatCnt <= '0;
            else
                beatCnt <= beatCnt + CntWidth'(1);
        end
    end

    // Level seen by the assembler when it loads the next word
    assign o_lastBeat = (beatCnt == LastIdx);

endmodule

//--- hw/serial2Axis.sv
/*
 * SPI to AXI-Stream bridge
 * Receiver, byte FIFO, word assembler and frame counter
 */
`timescale 1ns/1ps

module serial2Axis
(
    input  logic                   aclk,
    input  logic                   resetn,
    input  logic                   i_serialSck,
    input  logic                   i_serialNcs,
    input  logic                   i_serialMosi,
    input  logic                   i_axisReady,
    output logic                   o_serialMiso,
    output logic                   o_serialCts,
    output logic                   o_axisValid,
    output streamPkg::streamBeat_t o_axisBeat
);
    serialPkg::rxByte_t  rxByte;
    serialPkg::spiByte_t fifoHead;
    logic                fifoEmpty;
    logic                fifoPop;
    logic                beatAccept;
    logic                lastBeat;

    spiReceiver spiReceiverInst
    (
        .aclk         (aclk),
        .resetn       (resetn),
        .i_serialSck  (i_serialSck),
        .i_serialNcs  (i_serialNcs),
        .i_serialMosi (i_serialMosi),
        .o_serialMiso (o_serialMiso),
        .o_rx         (rxByte)
    );

    byteFifo byteFifoInst
    (
        .aclk        (aclk),
        .resetn      (resetn),
        .i_rx        (rxByte),
        .i_pop       (fifoPop),
        .o_head      (fifoHead),
        .o_empty     (fifoEmpty),
        .o_serialCts (o_serialCts)
    );

    wordAssembler wordAssemblerInst
    (
        .aclk       (aclk),
        .resetn     (resetn),
        .i_head     (fifoHead),
        .i_empty    (fifoEmpty),
        .i_ready    (i_axisReady),
        .i_lastBeat (lastBeat),
        .o_pop      (fifoPop),
        .o_valid    (o_axisValid),
        .o_accept   (beatAccept),
        .o_beat     (o_axisBeat)
    );

    frameCounter frameCounterInst
    (
        .aclk       (aclk),
        .resetn     (resetn),
        .i_accept   (beatAccept),
        .o_lastBeat (lastBeat)
    );

endmodule

//--- verif/serial2AxisTb.sv
/*
 * Testbench for the SPI to AXI-Stream bridge
 * SPI host driver, random tready, beat scoreboard and stream protocol checks
 */
`timescale 1ns/1ps
`include "serialBridge_cfg.svh"

module serial2AxisTb;

    localparam int CtsTimeout   = 4000;
    localparam int DrainTimeout = 4000;

    logic                   aclk      = 1'b0;
    logic                   axisReady = 1'b0;
    logic                   resetn;
    logic                   serialSck;
    logic                   serialNcs;
    logic                   serialMosi;
    logic                   serialMiso;
    logic                   serialCts;
    logic                   axisValid;
    streamPkg::streamBeat_t axisBeat;

    logic                   holdReady;
    logic                   nextReady;
    serialPkg::spiByte_t    sentBytes[$];
    serialPkg::spiByte_t    lastSent;
    int                     totalSent    = 0;
    int                     beatCount    = 0;
    int                     errorCount   = 0;
    int                     timeoutCount = 0;

    serial2Axis UUT
    (
        .aclk         (aclk),
        .resetn       (resetn),
        .i_serialSck  (serialSck),
        .i_serialNcs  (serialNcs),
        .i_serialMosi (serialMosi),
        .i_axisReady  (axisReady),
        .o_serialMiso (serialMiso),
        .o_serialCts  (serialCts),
        .o_axisValid  (axisValid),
        .o_axisBeat   (axisBeat)
    );

    always #10 aclk = ~aclk;

    // Ready is picked at the edge and driven 2 ns later
    always @(posedge aclk)
    begin
        nextReady = holdReady ? 1'b0 : (($urandom % 4) != 0);
        #2;
        axisReady = nextReady;
    end

    function automatic void flagMismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errorCount++;
    endfunction

    function automatic void flagTimeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        timeoutCount++;
    endfunction

    task automatic tick(input int cycles);
        repeat (cycles) @(posedge aclk);
        #2;
    endtask

    // First sent byte of the word sits in the lowest lane
    function automatic void checkBeat(input streamPkg::streamBeat_t beat);
        streamPkg::streamWord_t expWord;
        logic                   expLast;
        if (sentBytes.size() < 4)
        begin
            flagMismatch("word accepted before four bytes were sent");
            return;
        end
        expWord = {sentBytes[3], sentBytes[2], sentBytes[1], sentBytes[0]};
        expLast = ((beatCount % `SB_WORDS_PER_FRAME) == `SB_WORDS_PER_FRAME - 1);
        repeat (4) void'(sentBytes.pop_front());
        wordMatches: assert (beat.data == expWord)
            else flagMismatch($sformatf("beat %0d data %h, expected %h",
                                        beatCount, beat.data, expWord));
        lastMatches: assert (beat.last == expLast)
            else flagMismatch($sformatf("beat %0d last %0b, expected %0b",
                                        beatCount, beat.last, expLast));
        beatCount++;
    endfunction

    always @(posedge aclk)
    begin
        if (resetn && axisValid && axisReady)
            checkBeat(axisBeat);
    end

    beatHeld: assert property (@(posedge aclk) disable iff (!resetn)
        (axisValid && !axisReady) |=> (axisValid && $stable(axisBeat)))
        else flagMismatch("valid or beat changed while ready was low");

    function automatic void checkResetState();
        validLowAfterReset: assert (!axisValid)
            else flagMismatch("valid high after reset");
        lastLowAfterReset: assert (!axisBeat.last)
            else flagMismatch("last flag high after reset");
        ctsHighAfterReset: assert (serialCts)
            else flagMismatch("CTS low after reset");
    endfunction

    task automatic waitForCts();
        int cycles;
        cycles = 0;
        while (!serialCts && cycles < CtsTimeout)
        begin
            tick(1);
            cycles++;
        end
        if (!serialCts)
            flagTimeout("CTS never came back high");
    endtask

    task automatic waitForDrain();
        int cycles;
        cycles = 0;
        while ((sentBytes.size() != 0 || axisValid) && cycles < DrainTimeout)
        begin
            tick(1);
            cycles++;
        end
        if (sentBytes.size() != 0 || axisValid)
            flagTimeout("sent bytes never left the stream port");
    endtask

    // Mode 0 transfer at aclk/8, MISO is read just before each rising SCK
    task automatic sendBurst(input int count);
        serialPkg::spiByte_t txByte;
        serialPkg::spiByte_t txShift;
        serialPkg::spiByte_t echo;
        waitForCts();
        if (timeoutCount != 0)
            return;
        serialNcs = 1'b0;
        tick(4);
        repeat (count)
        begin
            txByte  = serialPkg::spiByte_t'($urandom);
            txShift = txByte;
            sentBytes.push_back(txByte);
            totalSent++;
            repeat (8)
            begin
                serialMosi = txShift[7];
                txShift    = txShift << 1;
                tick(4);
                echo      = {echo[6:0], serialMiso};
                serialSck = 1'b1;
                tick(4);
                serialSck = 1'b0;
            end
            echoMatches: assert (echo == lastSent)
                else flagMismatch($sformatf("MISO echo %h, expected %h", echo, lastSent));
            lastSent = txByte;
        end
        tick(2);
        serialNcs  = 1'b1;
        serialMosi = 1'b0;
        tick(6);
    endtask

    task automatic sendRandomTraffic(input int bursts);
        repeat (bursts)
        begin
            if (timeoutCount == 0)
                sendBurst(1 + int'($urandom % 4));
        end
        // Pad to whole words so the FIFO can drain completely
        while ((totalSent % 4) != 0 && timeoutCount == 0)
            sendBurst(1);
        if (timeoutCount == 0)
            waitForDrain();
    endtask

    // Assembler takes the first four bytes, everything after stays in the FIFO
    task automatic checkCtsBackpressure();
        int phaseSent;
        int buffered;
        if (timeoutCount != 0)
            return;
        holdReady = 1'b1;
        phaseSent = 0;
        while (serialCts && phaseSent < `SB_CTS_THRESHOLD + 8 && timeoutCount == 0)
        begin
            sendBurst(1);
            phaseSent++;
            buffered = (phaseSent > 4) ? phaseSent - 4 : 0;
            ctsTracksFill: assert (serialCts == (buffered <= `SB_CTS_THRESHOLD))
                else flagMismatch($sformatf("CTS %0b with %0d bytes buffered",
                                            serialCts, buffered));
        end
        ctsFellUnderBackpressure: assert (!serialCts)
            else flagMismatch("CTS stayed high with ready held low");
        holdReady = 1'b0;
        waitForCts();
    endtask

    initial
    begin
        void'($urandom(32'hf682331a));
        resetn     = 1'b0;
        serialSck  = 1'b0;
        serialNcs  = 1'b1;
        serialMosi = 1'b0;
        holdReady  = 1'b0;
        lastSent   = '0;
        repeat (4) @(posedge aclk);
        #2;
        resetn = 1'b1;
        tick(1);
        checkResetState();
        sendRandomTraffic(30);
        checkCtsBackpressure();
        sendRandomTraffic(30);
        $display("Summary: %0d bytes sent, %0d beats checked, %0d errors, %0d timeouts",
                 totalSent, beatCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- serial2Axis.f
+incdir+hw
hw/serialPkg.sv
hw/streamPkg.sv
hw/spiReceiver.sv
hw/byteFifo.sv
hw/wordAssembler.sv
hw/frameCounter.sv
hw/serial2Axis.sv
verif/serial2AxisTb.sv

//--- Makefile
# Verilator build and run of the SPI to AXI-Stream bridge testbench

VERILATOR ?= verilator
TOP       ?= serial2AxisTb
FILELIST  ?= serial2Axis.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR SIM_BIN LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	-./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
